//--- rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    localparam int instr_width = 32;
    localparam int pc_width    = 64;
    localparam int lreg_count  = 32;
    localparam int preg_count  = 64;
    localparam int rob_depth   = 16;
    // physical registers left over once every logical register has one
    localparam int free_depth  = preg_count - lreg_count;

    typedef logic [$clog2(lreg_count)-1:0] lreg_t;
    typedef logic [$clog2(preg_count)-1:0] preg_t;
    typedef logic [$clog2(rob_depth)-1:0]  rob_idx_t;

    // rv64i major opcodes handled by the decoder
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    typedef struct packed {
        logic [instr_width-1:0] instr;
        logic [pc_width-1:0]    pc;
        lreg_t                  lrs1;
        lreg_t                  lrs2;
        lreg_t                  lrd;
        logic                   need_to_wb;
    } decoded_t;

    // decoded fields plus the physical mapping picked in rename
    typedef struct packed {
        decoded_t dec;
        preg_t    prs1;
        preg_t    prs2;
        preg_t    prd;
        preg_t    old_prd;
    } renamed_t;

endpackage

`default_nettype wire

//--- rtl/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  logic [ctrl_pkg::instr_width-1:0] instr,
    input  logic [ctrl_pkg::pc_width-1:0]    pc,
    output ctrl_pkg::decoded_t               decoded
);

    logic [6:0] opcode;
    logic       use_rs1;
    logic       use_rs2;
    logic       writes_rd;

    assign opcode = instr[6:0];

    // register usage per opcode class
    always_comb begin
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            ctrl_pkg::opc_op: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b1;
            end
            ctrl_pkg::opc_op_imm, ctrl_pkg::opc_load: begin
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
            end
            ctrl_pkg::opc_store, ctrl_pkg::opc_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            ctrl_pkg::opc_lui: begin
                writes_rd = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        decoded.instr = instr;
        decoded.pc    = pc;
        // unused fields read as x0 so rename maps them to register 0
        decoded.lrs1  = use_rs1 ? instr[19:15] : '0;
        decoded.lrs2  = use_rs2 ? instr[24:20] : '0;
        decoded.lrd   = writes_rd ? instr[11:7] : '0;
        // a write to x0 is dropped
        decoded.need_to_wb = writes_rd && (instr[11:7] != 5'd0);
    end

endmodule

`default_nettype wire

//--- rtl/stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // take a new item when empty or when the held one leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/free_list.sv
`timescale 1ns/1ns
`default_nettype none

module free_list (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            alloc_valid,
    output ctrl_pkg::preg_t alloc_preg,
    output logic            empty,
    input  logic            free_valid,
    input  ctrl_pkg::preg_t free_preg
);

    typedef logic [$clog2(ctrl_pkg::free_depth)-1:0] ptr_t;
    typedef logic [$clog2(ctrl_pkg::free_depth):0]   count_t;

    ctrl_pkg::preg_t queue [ctrl_pkg::free_depth];
    ptr_t            head;
    ptr_t            tail;
    count_t          count;

    assign alloc_preg = queue[head];
    assign empty      = (count == '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            // starts full, holding the registers above the architectural ones
            for (int i = 0; i < ctrl_pkg::free_depth; i++) begin
                queue[i] <= ctrl_pkg::preg_t'(ctrl_pkg::lreg_count + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= count_t'(ctrl_pkg::free_depth);
        end else begin
            if (alloc_valid) begin
                head <= head + 1'b1;
            end
            // committed registers go back at the tail
            if (free_valid) begin
                queue[tail] <= free_preg;
                tail        <= tail + 1'b1;
            end
            case ({free_valid, alloc_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/rename_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rename_stage (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  ctrl_pkg::decoded_t in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output ctrl_pkg::renamed_t out_data,
    input  logic               free_valid,
    input  ctrl_pkg::preg_t    free_preg
);

    ctrl_pkg::preg_t rat [ctrl_pkg::lreg_count];
    logic            need_preg;
    logic            stall;
    logic            fire;
    logic            fl_alloc;
    logic            fl_empty;
    ctrl_pkg::preg_t fl_preg;

    assign need_preg = in_data.need_to_wb;
    // hold while a destination is needed and none is left
    assign stall     = need_preg && fl_empty;
    assign out_valid = in_valid && !stall;
    assign in_ready  = out_ready && !stall;
    assign fire      = in_valid && in_ready;
    assign fl_alloc  = fire && need_preg;

    always_comb begin
        out_data.dec     = in_data;
        out_data.prs1    = rat[in_data.lrs1];
        out_data.prs2    = rat[in_data.lrs2];
        out_data.old_prd = rat[in_data.lrd];
        out_data.prd     = need_preg ? fl_preg : '0;
    end

    // speculative alias table, identity after reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < ctrl_pkg::lreg_count; i++) begin
                rat[i] <= ctrl_pkg::preg_t'(i);
            end
        end else if (fl_alloc) begin
            rat[in_data.lrd] <= fl_preg;
        end
    end

    free_list u_free_list (
        .clock      (clock),
        .reset_n    (reset_n),
        .alloc_valid(fl_alloc),
        .alloc_preg (fl_preg),
        .empty      (fl_empty),
        .free_valid (free_valid),
        .free_preg  (free_preg)
    );

endmodule

`default_nettype wire

//--- rtl/busy_table.sv
`timescale 1ns/1ns
`default_nettype none

module busy_table (
    input  logic            clock,
    input  logic            reset_n,
    input  ctrl_pkg::preg_t read_preg1,
    input  ctrl_pkg::preg_t read_preg2,
    output logic            ready1,
    output logic            ready2,
    input  logic            alloc_valid,
    input  ctrl_pkg::preg_t alloc_preg,
    input  logic            clear_valid,
    input  ctrl_pkg::preg_t clear_preg
);

    logic [ctrl_pkg::preg_count-1:0] busy;

    assign ready1 = !busy[read_preg1];
    assign ready2 = !busy[read_preg2];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else begin
            if (clear_valid) begin
                busy[clear_preg] <= 1'b0;
            end
            // register 0 holds x0 and is always ready
            if (alloc_valid && alloc_preg != '0) begin
                busy[alloc_preg] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  ctrl_pkg::renamed_t in_data,
    output logic               to_issue_valid,
    input  logic               to_issue_ready,
    output logic               robidx_flag,
    output ctrl_pkg::rob_idx_t robidx,
    output logic               busy_alloc_valid,
    input  logic               writeback_valid,
    input  ctrl_pkg::rob_idx_t writeback_robidx,
    output logic               busy_clear_valid,
    output ctrl_pkg::preg_t    busy_clear_preg,
    output logic               commit_valid,
    output ctrl_pkg::lreg_t    commit_lrd,
    output ctrl_pkg::preg_t    commit_prd,
    output logic               free_valid,
    output ctrl_pkg::preg_t    free_preg
);

    ctrl_pkg::lreg_t                lrd_q     [ctrl_pkg::rob_depth];
    ctrl_pkg::preg_t                prd_q     [ctrl_pkg::rob_depth];
    ctrl_pkg::preg_t                old_prd_q [ctrl_pkg::rob_depth];
    logic [ctrl_pkg::rob_depth-1:0] wb_q;
    logic [ctrl_pkg::rob_depth-1:0] done_q;
    ctrl_pkg::rob_idx_t             head;
    ctrl_pkg::rob_idx_t             tail;
    logic                           head_flag;
    logic                           tail_flag;
    logic                           full;
    logic                           empty;
    logic                           enq;

    // flag bit tells full from empty when the indices meet
    assign full  = (head == tail) && (head_flag != tail_flag);
    assign empty = (head == tail) && (head_flag == tail_flag);

    assign to_issue_valid   = in_valid && !full;
    assign in_ready         = to_issue_ready && !full;
    assign enq              = to_issue_valid && to_issue_ready;
    assign robidx           = tail;
    assign robidx_flag      = tail_flag;
    assign busy_alloc_valid = enq && in_data.dec.need_to_wb;

    assign busy_clear_valid = writeback_valid && wb_q[writeback_robidx];
    assign busy_clear_preg  = prd_q[writeback_robidx];

    // head retires once written back, one per cycle
    assign commit_valid = !empty && done_q[head];
    assign commit_lrd   = lrd_q[head];
    assign commit_prd   = prd_q[head];
    assign free_valid   = commit_valid && wb_q[head];
    assign free_preg    = old_prd_q[head];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head      <= '0;
            head_flag <= 1'b0;
            tail      <= '0;
            tail_flag <= 1'b0;
            done_q    <= '0;
        end else begin
            if (enq) begin
                {tail_flag, tail} <= {tail_flag, tail} + 1'b1;
                done_q[tail]      <= 1'b0;
            end
            if (writeback_valid) begin
                done_q[writeback_robidx] <= 1'b1;
            end
            if (commit_valid) begin
                {head_flag, head} <= {head_flag, head} + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq) begin
            lrd_q[tail]     <= in_data.dec.lrd;
            prd_q[tail]     <= in_data.prd;
            old_prd_q[tail] <= in_data.old_prd;
            wb_q[tail]      <= in_data.dec.need_to_wb;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ctrl_block.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_block (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             ibuffer_instr_valid,
    input  logic [ctrl_pkg::instr_width-1:0] ibuffer_inst_out,
    input  logic [ctrl_pkg::pc_width-1:0]    ibuffer_pc_out,
    output logic                             ibuffer_ready,
    input  logic                             to_issue_ready,
    output logic                             to_issue_valid,
    output logic [ctrl_pkg::instr_width-1:0] to_issue_instr,
    output logic [ctrl_pkg::pc_width-1:0]    to_issue_pc,
    output ctrl_pkg::lreg_t                  to_issue_lrs1,
    output ctrl_pkg::lreg_t                  to_issue_lrs2,
    output ctrl_pkg::lreg_t                  to_issue_lrd,
    output logic                             to_issue_need_to_wb,
    output ctrl_pkg::preg_t                  to_issue_prs1,
    output ctrl_pkg::preg_t                  to_issue_prs2,
    output ctrl_pkg::preg_t                  to_issue_prd,
    output ctrl_pkg::preg_t                  to_issue_old_prd,
    output logic                             to_issue_robidx_flag,
    output ctrl_pkg::rob_idx_t               to_issue_robidx,
    output logic                             to_issue_src1_ready,
    output logic                             to_issue_src2_ready,
    input  logic                             writeback_valid,
    input  ctrl_pkg::rob_idx_t               writeback_robidx,
    output logic                             commit_valid,
    output ctrl_pkg::lreg_t                  commit_lrd,
    output ctrl_pkg::preg_t                  commit_prd
);

    ctrl_pkg::decoded_t dec_data;
    ctrl_pkg::decoded_t ren_in_data;
    logic               ren_in_valid;
    logic               ren_in_ready;
    ctrl_pkg::renamed_t ren_out_data;
    logic               ren_out_valid;
    logic               ren_out_ready;
    ctrl_pkg::renamed_t issue_data;
    logic               issue_in_valid;
    logic               issue_in_ready;
    logic               free_valid;
    ctrl_pkg::preg_t    free_preg;
    logic               busy_alloc_valid;
    logic               busy_clear_valid;
    ctrl_pkg::preg_t    busy_clear_preg;

    // issue lane comes straight from the rename register
    assign to_issue_instr      = issue_data.dec.instr;
    assign to_issue_pc         = issue_data.dec.pc;
    assign to_issue_lrs1       = issue_data.dec.lrs1;
    assign to_issue_lrs2       = issue_data.dec.lrs2;
    assign to_issue_lrd        = issue_data.dec.lrd;
    assign to_issue_need_to_wb = issue_data.dec.need_to_wb;
    assign to_issue_prs1       = issue_data.prs1;
    assign to_issue_prs2       = issue_data.prs2;
    assign to_issue_prd        = issue_data.prd;
    assign to_issue_old_prd    = issue_data.old_prd;

    instr_decode u_instr_decode (
        .instr  (ibuffer_inst_out),
        .pc     (ibuffer_pc_out),
        .decoded(dec_data)
    );

    stage_reg #(
        .payload_t(ctrl_pkg::decoded_t)
    ) decode_reg (
        .clock    (clock),
        .reset_n  (reset_n),
        .in_valid (ibuffer_instr_valid),
        .in_ready (ibuffer_ready),
        .in_data  (dec_data),
        .out_valid(ren_in_valid),
        .out_ready(ren_in_ready),
        .out_data (ren_in_data)
    );

    rename_stage u_rename_stage (
        .clock     (clock),
        .reset_n   (reset_n),
        .in_valid  (ren_in_valid),
        .in_ready  (ren_in_ready),
        .in_data   (ren_in_data),
        .out_valid (ren_out_valid),
        .out_ready (ren_out_ready),
        .out_data  (ren_out_data),
        .free_valid(free_valid),
        .free_preg (free_preg)
    );

    stage_reg #(
        .payload_t(ctrl_pkg::renamed_t)
    ) rename_reg (
        .clock    (clock),
        .reset_n  (reset_n),
        .in_valid (ren_out_valid),
        .in_ready (ren_out_ready),
        .in_data  (ren_out_data),
        .out_valid(issue_in_valid),
        .out_ready(issue_in_ready),
        .out_data (issue_data)
    );

    reorder_buffer u_reorder_buffer (
        .clock           (clock),
        .reset_n         (reset_n),
        .in_valid        (issue_in_valid),
        .in_ready        (issue_in_ready),
        .in_data         (issue_data),
        .to_issue_valid  (to_issue_valid),
        .to_issue_ready  (to_issue_ready),
        .robidx_flag     (to_issue_robidx_flag),
        .robidx          (to_issue_robidx),
        .busy_alloc_valid(busy_alloc_valid),
        .writeback_valid (writeback_valid),
        .writeback_robidx(writeback_robidx),
        .busy_clear_valid(busy_clear_valid),
        .busy_clear_preg (busy_clear_preg),
        .commit_valid    (commit_valid),
        .commit_lrd      (commit_lrd),
        .commit_prd      (commit_prd),
        .free_valid      (free_valid),
        .free_preg       (free_preg)
    );

    busy_table u_busy_table (
        .clock      (clock),
        .reset_n    (reset_n),
        .read_preg1 (issue_data.prs1),
        .read_preg2 (issue_data.prs2),
        .ready1     (to_issue_src1_ready),
        .ready2     (to_issue_src2_ready),
        .alloc_valid(busy_alloc_valid),
        .alloc_preg (issue_data.prd),
        .clear_valid(busy_clear_valid),
        .clear_preg (busy_clear_preg)
    );

endmodule

`default_nettype wire

//--- verif/ctrl_block_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ctrl_block_tb;

    localparam int entry_count  = 48;
    localparam int clock_period = 40;
    localparam int hold_cycles  = 8;

    logic                             clock;
    logic                             reset_n;
    logic                             ibuffer_instr_valid;
    logic [ctrl_pkg::instr_width-1:0] ibuffer_inst_out;
    logic [ctrl_pkg::pc_width-1:0]    ibuffer_pc_out;
    logic                             ibuffer_ready;
    logic                             to_issue_ready;
    logic                             to_issue_valid;
    logic [ctrl_pkg::instr_width-1:0] to_issue_instr;
    logic [ctrl_pkg::pc_width-1:0]    to_issue_pc;
    ctrl_pkg::lreg_t                  to_issue_lrs1;
    ctrl_pkg::lreg_t                  to_issue_lrs2;
    ctrl_pkg::lreg_t                  to_issue_lrd;
    logic                             to_issue_need_to_wb;
    ctrl_pkg::preg_t                  to_issue_prs1;
    ctrl_pkg::preg_t                  to_issue_prs2;
    ctrl_pkg::preg_t                  to_issue_prd;
    ctrl_pkg::preg_t                  to_issue_old_prd;
    logic                             to_issue_robidx_flag;
    ctrl_pkg::rob_idx_t               to_issue_robidx;
    logic                             to_issue_src1_ready;
    logic                             to_issue_src2_ready;
    logic                             writeback_valid;
    ctrl_pkg::rob_idx_t               writeback_robidx;
    logic                             commit_valid;
    ctrl_pkg::lreg_t                  commit_lrd;
    ctrl_pkg::preg_t                  commit_prd;

    // stimulus table with expected decode fields
    logic [31:0]     tbl_instr [entry_count];
    ctrl_pkg::lreg_t tbl_lrs1  [entry_count];
    ctrl_pkg::lreg_t tbl_lrs2  [entry_count];
    ctrl_pkg::lreg_t tbl_lrd   [entry_count];
    logic            tbl_wb    [entry_count];

    // reference rename and commit state
    ctrl_pkg::preg_t alias_m  [ctrl_pkg::lreg_count];
    logic            busy_m   [ctrl_pkg::preg_count];
    ctrl_pkg::preg_t free_q   [$];
    ctrl_pkg::preg_t seq_prd  [entry_count];
    ctrl_pkg::preg_t seq_old  [entry_count];
    logic            seq_done [entry_count];
    int              entry_err [entry_count];
    int              pending  [$];

    int   wb_seq;
    int   feed_idx;
    int   issue_seq;
    int   commit_seq;
    int   errors;
    int   tests_run;
    int   tests_failed;
    int   full_cycles;
    int   bp_errors;
    int   ready_hold;
    logic ready_hold_done;
    logic wb_enable;
    logic running;

    ctrl_block dut (.*);

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic logic [63:0] pc_for_entry(input int i);
        return 64'h8000_0000 + 64'(i * 4);
    endfunction

    task automatic build_table();
        logic [6:0] opc;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       writes;
        for (int i = 0; i < entry_count; i++) begin
            // a few entries target x0
            rd  = (i % 13 == 6) ? 5'd0 : 5'((i * 7 + 3) % 31 + 1);
            rs1 = 5'((i * 5 + 1) % 32);
            rs2 = 5'((i * 3 + 2) % 32);
            case (i % 8)
                0, 3, 6: opc = ctrl_pkg::opc_op;
                1, 7:    opc = ctrl_pkg::opc_op_imm;
                2:       opc = ctrl_pkg::opc_load;
                5:       opc = ctrl_pkg::opc_lui;
                default: begin
                    case ((i / 8) % 6)
                        0, 3:    opc = ctrl_pkg::opc_store;
                        1, 4:    opc = ctrl_pkg::opc_branch;
                        2:       opc = 7'b0010111;
                        default: opc = 7'b1101111;
                    endcase
                end
            endcase
            tbl_instr[i] = {7'(i), rs2, rs1, 3'b000, rd, opc};
            writes = opc inside {ctrl_pkg::opc_op, ctrl_pkg::opc_op_imm,
                                 ctrl_pkg::opc_load, ctrl_pkg::opc_lui};
            tbl_lrs1[i] = (opc inside {ctrl_pkg::opc_op, ctrl_pkg::opc_op_imm,
                                       ctrl_pkg::opc_load, ctrl_pkg::opc_store,
                                       ctrl_pkg::opc_branch}) ? rs1 : 5'd0;
            tbl_lrs2[i] = (opc inside {ctrl_pkg::opc_op, ctrl_pkg::opc_store,
                                       ctrl_pkg::opc_branch}) ? rs2 : 5'd0;
            tbl_lrd[i]  = writes ? rd : 5'd0;
            tbl_wb[i]   = writes && (rd != 5'd0);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp, input int s);
        if (s >= 0 && s < entry_count) begin
            $display("[FAIL] entry %0d %s: got 0x%0h, expected 0x%0h", s, name, got, exp);
            entry_err[s]++;
        end else begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
        errors++;
    endtask

    task automatic observe_commit();
        int   s;
        logic expect_commit;
        s = commit_seq;
        expect_commit = (s < issue_seq) && seq_done[s];
        if (commit_valid !== expect_commit) begin
            report_mismatch("commit_valid", commit_valid, expect_commit, s);
        end
        if (commit_valid && expect_commit) begin
            if (commit_lrd !== tbl_lrd[s]) begin
                report_mismatch("commit_lrd", commit_lrd, tbl_lrd[s], s);
            end
            if (commit_prd !== seq_prd[s]) begin
                report_mismatch("commit_prd", commit_prd, seq_prd[s], s);
            end
            // the overwritten mapping goes back to the free list
            if (tbl_wb[s]) begin
                free_q.push_back(seq_old[s]);
            end
            tests_run++;
            if (entry_err[s] == 0) begin
                $display("entry %0d committed ok (x%0d -> p%0d)", s, tbl_lrd[s], seq_prd[s]);
            end else begin
                $display("entry %0d committed with %0d mismatches", s, entry_err[s]);
                tests_failed++;
            end
            commit_seq++;
        end
    endtask

    task automatic observe_issue();
        int                 s;
        ctrl_pkg::preg_t    exp_prs1;
        ctrl_pkg::preg_t    exp_prs2;
        ctrl_pkg::preg_t    exp_old;
        ctrl_pkg::preg_t    exp_prd;
        ctrl_pkg::rob_idx_t exp_idx;
        logic               exp_flag;
        s = issue_seq;
        if (s >= entry_count) begin
            $display("an extra instruction was issued after all %0d entries", entry_count);
            errors++;
        end else begin
            exp_prs1 = alias_m[tbl_lrs1[s]];
            exp_prs2 = alias_m[tbl_lrs2[s]];
            exp_old  = alias_m[tbl_lrd[s]];
            exp_prd  = '0;
            if (tbl_wb[s]) begin
                if (free_q.size() == 0) begin
                    $display("entry %0d got a register while the model free list was empty", s);
                    errors++;
                    entry_err[s]++;
                end else begin
                    exp_prd = free_q.pop_front();
                end
            end
            exp_idx  = ctrl_pkg::rob_idx_t'(s % ctrl_pkg::rob_depth);
            exp_flag = ((s / ctrl_pkg::rob_depth) % 2) == 1;
            if (to_issue_instr !== tbl_instr[s]) begin
                report_mismatch("to_issue_instr", to_issue_instr, tbl_instr[s], s);
            end
            if (to_issue_pc !== pc_for_entry(s)) begin
                report_mismatch("to_issue_pc", to_issue_pc, pc_for_entry(s), s);
            end
            if (to_issue_lrs1 !== tbl_lrs1[s]) begin
                report_mismatch("to_issue_lrs1", to_issue_lrs1, tbl_lrs1[s], s);
            end
            if (to_issue_lrs2 !== tbl_lrs2[s]) begin
                report_mismatch("to_issue_lrs2", to_issue_lrs2, tbl_lrs2[s], s);
            end
            if (to_issue_lrd !== tbl_lrd[s]) begin
                report_mismatch("to_issue_lrd", to_issue_lrd, tbl_lrd[s], s);
            end
            if (to_issue_need_to_wb !== tbl_wb[s]) begin
                report_mismatch("to_issue_need_to_wb", to_issue_need_to_wb, tbl_wb[s], s);
            end
            if (to_issue_prs1 !== exp_prs1) begin
                report_mismatch("to_issue_prs1", to_issue_prs1, exp_prs1, s);
            end
            if (to_issue_prs2 !== exp_prs2) begin
                report_mismatch("to_issue_prs2", to_issue_prs2, exp_prs2, s);
            end
            if (to_issue_prd !== exp_prd) begin
                report_mismatch("to_issue_prd", to_issue_prd, exp_prd, s);
            end
            if (to_issue_old_prd !== exp_old) begin
                report_mismatch("to_issue_old_prd", to_issue_old_prd, exp_old, s);
            end
            if (to_issue_robidx !== exp_idx) begin
                report_mismatch("to_issue_robidx", to_issue_robidx, exp_idx, s);
            end
            if (to_issue_robidx_flag !== exp_flag) begin
                report_mismatch("to_issue_robidx_flag", to_issue_robidx_flag, exp_flag, s);
            end
            if (to_issue_src1_ready !== !busy_m[exp_prs1]) begin
                report_mismatch("to_issue_src1_ready", to_issue_src1_ready,
                                !busy_m[exp_prs1], s);
            end
            if (to_issue_src2_ready !== !busy_m[exp_prs2]) begin
                report_mismatch("to_issue_src2_ready", to_issue_src2_ready,
                                !busy_m[exp_prs2], s);
            end
            if (tbl_wb[s]) begin
                alias_m[tbl_lrd[s]] = exp_prd;
                busy_m[exp_prd]     = 1'b1;
            end
            seq_prd[s] = exp_prd;
            seq_old[s] = exp_old;
            pending.push_back(s);
            issue_seq++;
        end
    endtask

    task automatic apply_writeback();
        seq_done[wb_seq] = 1'b1;
        if (tbl_wb[wb_seq]) begin
            busy_m[seq_prd[wb_seq]] = 1'b0;
        end
    endtask

    // ROB stays full until writebacks are let through
    task automatic watch_rob_full();
        full_cycles++;
        if (full_cycles == 1) begin
            bp_errors = errors;
        end
        if (full_cycles == hold_cycles) begin
            if (ibuffer_ready !== 1'b0) begin
                report_mismatch("ibuffer_ready", ibuffer_ready, 0, -1);
            end
            if (to_issue_valid !== 1'b0) begin
                report_mismatch("to_issue_valid", to_issue_valid, 0, -1);
            end
            tests_run++;
            if (errors == bp_errors) begin
                $display("rob full back-pressure ok");
            end else begin
                $display("rob full back-pressure: %0d mismatches", errors - bp_errors);
                tests_failed++;
            end
            wb_enable = 1'b1;
        end
    endtask

    task automatic drive_inputs();
        int k;
        if (ibuffer_instr_valid && ibuffer_ready) begin
            feed_idx++;
        end
        if (feed_idx < entry_count) begin
            ibuffer_instr_valid <= 1'b1;
            ibuffer_inst_out    <= tbl_instr[feed_idx];
            ibuffer_pc_out      <= pc_for_entry(feed_idx);
        end else begin
            ibuffer_instr_valid <= 1'b0;
        end
        // one long issue stall in the middle of the run
        if (issue_seq == 30 && !ready_hold_done) begin
            ready_hold      = 10;
            ready_hold_done = 1'b1;
        end
        if (ready_hold > 0) begin
            to_issue_ready <= 1'b0;
            ready_hold--;
        end else begin
            to_issue_ready <= ($urandom % 4) != 0;
        end
        if (wb_enable && pending.size() > 0 && ($urandom % 3) != 0) begin
            k      = int'($urandom % 32'(pending.size()));
            wb_seq = pending[k];
            pending.delete(k);
            writeback_valid  <= 1'b1;
            writeback_robidx <= ctrl_pkg::rob_idx_t'(wb_seq % ctrl_pkg::rob_depth);
        end else begin
            writeback_valid <= 1'b0;
        end
    endtask

    always @(posedge clock) begin
        if (running) begin
            if (to_issue_valid && (issue_seq - commit_seq) >= ctrl_pkg::rob_depth) begin
                report_mismatch("to_issue_valid", to_issue_valid, 0, issue_seq);
            end
            observe_commit();
            if (to_issue_valid && to_issue_ready) begin
                observe_issue();
            end
            if (writeback_valid) begin
                apply_writeback();
            end
            if (!wb_enable && issue_seq >= ctrl_pkg::rob_depth) begin
                watch_rob_full();
            end
            drive_inputs();
        end
    end

    initial begin
        int reset_errors;
        void'($urandom(32'h8e5a1414));
        reset_n             = 1'b0;
        ibuffer_instr_valid = 1'b0;
        ibuffer_inst_out    = '0;
        ibuffer_pc_out      = '0;
        to_issue_ready      = 1'b0;
        writeback_valid     = 1'b0;
        writeback_robidx    = '0;
        running         = 1'b0;
        wb_enable       = 1'b0;
        ready_hold_done = 1'b0;
        ready_hold      = 0;
        wb_seq          = 0;
        feed_idx        = 0;
        issue_seq       = 0;
        commit_seq      = 0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        full_cycles     = 0;
        bp_errors       = 0;
        build_table();
        for (int i = 0; i < ctrl_pkg::lreg_count; i++) begin
            alias_m[i] = ctrl_pkg::preg_t'(i);
            free_q.push_back(ctrl_pkg::preg_t'(ctrl_pkg::lreg_count + i));
        end
        for (int i = 0; i < ctrl_pkg::preg_count; i++) begin
            busy_m[i] = 1'b0;
        end
        for (int i = 0; i < entry_count; i++) begin
            seq_done[i]  = 1'b0;
            entry_err[i] = 0;
        end
        repeat (4) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        tests_run++;
        reset_errors = errors;
        if (ibuffer_ready !== 1'b1) begin
            report_mismatch("ibuffer_ready", ibuffer_ready, 1, -1);
        end
        if (to_issue_valid !== 1'b0) begin
            report_mismatch("to_issue_valid", to_issue_valid, 0, -1);
        end
        if (commit_valid !== 1'b0) begin
            report_mismatch("commit_valid", commit_valid, 0, -1);
        end
        if (errors == reset_errors) begin
            $display("reset state ok");
        end else begin
            $display("reset state: %0d mismatches", errors - reset_errors);
            tests_failed++;
        end
        running <= 1'b1;
        wait (commit_seq == entry_count);
        @(posedge clock);
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // generous bound per table entry
    initial begin
        #(entry_count * 60 * clock_period);
        $display("timeout with %0d of %0d entries committed", commit_seq, entry_count);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/ctrl_pkg.sv
rtl/instr_decode.sv
rtl/stage_reg.sv
rtl/free_list.sv
rtl/rename_stage.sv
rtl/busy_table.sv
rtl/reorder_buffer.sv
rtl/ctrl_block.sv
verif/ctrl_block_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module ctrl_block_tb \
    -o ctrl_block_sim

output=$(./obj_dir/ctrl_block_sim)
echo "$output"

if grep -q "Simulation PASSED" <<< "$output"; then
    exit 0
fi
exit 1
